// ==== hw/mul_pkg.sv ====
package mul_pkg;

	localparam int MUL_STATE_W = 2; // controller state width

	// sequencer states, encoding follows the original next-state block
	typedef enum logic [MUL_STATE_W-1:0] {
		IDLE = 2'b00, // waiting for op_start
		EXEC = 2'b01, // booth iterations running
		DONE = 2'b10  // one-cycle completion state
	} mul_state_t;

	localparam int MUL_OP_WIDTH_DEF = 32; // default operand width, must be even

endpackage

// ==== hw/multiplier_ns.sv ====
`timescale 1ns/100ps

module multiplier_ns
	import mul_pkg::*;
#(
	parameter int OP_WIDTH = MUL_OP_WIDTH_DEF,
	localparam int CNT_W = $clog2(OP_WIDTH / 2 + 1)
)
(
	input  logic                       op_start,  // level, low pauses exec
	input  logic                       op_clear,  // abort and zero
	input  logic                       reset_n,
	input  mul_state_t                 state,
	input  logic [CNT_W-1:0]           count,
	input  logic signed [OP_WIDTH-1:0] multiplier,   // from the pins
	input  logic signed [OP_WIDTH-1:0] multiplicand,
	input  logic signed [OP_WIDTH-1:0] prev_multiplier,   // last started pair
	input  logic signed [OP_WIDTH-1:0] prev_multiplicand,
	input  logic                       guard_armed,
	output mul_state_t                 next_state,
	output logic [CNT_W-1:0]           next_count,
	output logic signed [OP_WIDTH-1:0] next_multiplier,
	output logic signed [OP_WIDTH-1:0] next_multiplicand,
	output logic                       next_guard_armed,
	output logic signed [OP_WIDTH-1:0] next_prev_multiplier,
	output logic signed [OP_WIDTH-1:0] next_prev_multiplicand
);

	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(OP_WIDTH / 2); // iterations per op

	logic same_ops; // pins still hold the pair that last ran

	assign same_ops = (multiplier == prev_multiplier) && (multiplicand == prev_multiplicand);

	always_comb
	begin
		next_state             = state; // hold unless a branch says otherwise
		next_count             = count;
		next_multiplier        = multiplier;
		next_multiplicand      = multiplicand;
		next_guard_armed       = guard_armed;
		next_prev_multiplier   = prev_multiplier;
		next_prev_multiplicand = prev_multiplicand;
		if (!reset_n)
		begin
			next_state        = IDLE; // everything back to power-up values
			next_count        = '0;
			next_multiplier   = '0;
			next_multiplicand = '0;
			next_guard_armed  = 1'b1;
		end
		else
		begin
			case (state)
			IDLE:
			begin
				if (op_clear)
				begin
					next_count        = '0; // clear beats start
					next_multiplier   = '0;
					next_multiplicand = '0;
					next_guard_armed  = 1'b1;
				end
				else if (!op_start)
				begin
					next_prev_multiplier   = multiplier; // track pins while idle
					next_prev_multiplicand = multiplicand;
					next_guard_armed       = 1'b1; // start dropped, rearm
				end
				else if (!guard_armed && same_ops)
				begin
					next_state = IDLE; // same pair still held high, no rerun
				end
				else
				begin
					next_state             = EXEC;
					next_count             = '0;
					next_prev_multiplier   = multiplier; // capture pair for the run
					next_prev_multiplicand = multiplicand;
				end
			end
			EXEC:
			begin
				next_multiplier   = prev_multiplier; // operands frozen during run
				next_multiplicand = prev_multiplicand;
				if (op_clear)
				begin
					next_state        = IDLE;
					next_count        = '0;
					next_multiplier   = '0;
					next_multiplicand = '0;
					next_guard_armed  = 1'b1;
				end
				else if (!op_start)
					next_state = EXEC; // paused, count holds
				else if (count != CNT_LAST)
					next_count = count + 1'b1;
				else
				begin
					next_state       = DONE;
					next_count       = '0;
					next_guard_armed = 1'b0; // finished, block rerun of same pair
				end
			end
			DONE:
			begin
				next_state        = IDLE; // always one cycle
				next_count        = '0;
				next_multiplier   = prev_multiplier;
				next_multiplicand = prev_multiplicand;
				if (op_clear)
				begin
					next_multiplier   = '0;
					next_multiplicand = '0;
					next_guard_armed  = 1'b1;
				end
			end
			default:
			begin
				next_state = IDLE; // unused code, recover
				next_count = '0;
			end
			endcase
		end
	end

endmodule

// ==== hw/multiplier_ctrl.sv ====
`timescale 1ns/100ps

module multiplier_ctrl
	import mul_pkg::*;
#(
	parameter int OP_WIDTH = MUL_OP_WIDTH_DEF
)
(
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       op_start,
	input  logic                       op_clear,
	input  logic signed [OP_WIDTH-1:0] multiplier,
	input  logic signed [OP_WIDTH-1:0] multiplicand,
	output mul_state_t                 state,
	output logic signed [OP_WIDTH-1:0] reg_multiplier,
	output logic signed [OP_WIDTH-1:0] reg_multiplicand,
	output logic                       load_op,  // one cycle after start
	output logic                       step_op,  // one per counted iteration
	output logic                       clear_op, // level
	output logic                       op_done,
	output logic                       busy
);

	localparam int CNT_W = $clog2(OP_WIDTH / 2 + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(OP_WIDTH / 2);

	logic [CNT_W-1:0]           count;
	logic                       guard_armed;
	logic signed [OP_WIDTH-1:0] prev_multiplier;
	logic signed [OP_WIDTH-1:0] prev_multiplicand;
	mul_state_t                 next_state;
	logic [CNT_W-1:0]           next_count;
	logic signed [OP_WIDTH-1:0] next_multiplier;
	logic signed [OP_WIDTH-1:0] next_multiplicand;
	logic                       next_guard_armed;
	logic signed [OP_WIDTH-1:0] next_prev_multiplier;
	logic signed [OP_WIDTH-1:0] next_prev_multiplicand;

	multiplier_ns #(
		.OP_WIDTH (OP_WIDTH)
	) u_ns (
		.op_start               (op_start),
		.op_clear               (op_clear),
		.reset_n                (reset_n),
		.state                  (state),
		.count                  (count),
		.multiplier             (multiplier),
		.multiplicand           (multiplicand),
		.prev_multiplier        (prev_multiplier),
		.prev_multiplicand      (prev_multiplicand),
		.guard_armed            (guard_armed),
		.next_state             (next_state),
		.next_count             (next_count),
		.next_multiplier        (next_multiplier),
		.next_multiplicand      (next_multiplicand),
		.next_guard_armed       (next_guard_armed),
		.next_prev_multiplier   (next_prev_multiplier),
		.next_prev_multiplicand (next_prev_multiplicand)
	);

	assign clear_op = op_clear; // accumulator zeroes while held

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state             <= IDLE;
			count             <= '0;
			reg_multiplier    <= '0;
			reg_multiplicand  <= '0;
			prev_multiplier   <= '0;
			prev_multiplicand <= '0;
			guard_armed       <= 1'b1; // armed out of reset
			load_op           <= 1'b0;
			step_op           <= 1'b0;
			op_done           <= 1'b0;
			busy              <= 1'b0;
		end
		else
		begin
			state             <= next_state;
			count             <= next_count;
			reg_multiplier    <= next_multiplier;
			reg_multiplicand  <= next_multiplicand;
			prev_multiplier   <= next_prev_multiplier;
			prev_multiplicand <= next_prev_multiplicand;
			guard_armed       <= next_guard_armed;
			load_op           <= (state == IDLE) && (next_state == EXEC); // start taken
			step_op           <= (state == EXEC) && op_start && !op_clear
				&& (count < CNT_LAST); // count just advanced
			op_done           <= (state == DONE); // lags state by one
			busy              <= (state == EXEC);
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!reset_n)
		state != 2'b11)
		else $error("controller in unused state encoding");

	a_count_range: assert property (@(posedge clk) disable iff (!reset_n)
		count <= CNT_LAST)
		else $error("iteration count past last step");

	a_done_after_exec: assert property (@(posedge clk) disable iff (!reset_n)
		(state == DONE) |-> ($past(state) == EXEC))
		else $error("DONE entered from a state other than EXEC");

endmodule

// ==== hw/booth_radix4_step.sv ====
`timescale 1ns/100ps

module booth_radix4_step
	import mul_pkg::*;
#(
	parameter int OP_WIDTH = MUL_OP_WIDTH_DEF
)
(
	input  logic signed [OP_WIDTH+1:0] acc_hi,   // partial product, 2 guard bits
	input  logic        [OP_WIDTH-1:0] acc_lo,   // multiplier bits not yet used
	input  logic                       prev_bit, // bit shifted out last step
	input  logic signed [OP_WIDTH-1:0] multiplicand,
	output logic signed [OP_WIDTH+1:0] new_acc_hi,
	output logic        [OP_WIDTH-1:0] new_acc_lo,
	output logic                       new_prev_bit
);

	logic [2:0]                 booth_code; // two bits plus the one below
	logic signed [OP_WIDTH+1:0] mcand_ext;  // multiplicand at hi width
	logic signed [OP_WIDTH+1:0] pp;         // selected partial product
	logic signed [OP_WIDTH+1:0] sum;

	assign booth_code = {acc_lo[1:0], prev_bit};
	assign mcand_ext  = {{2{multiplicand[OP_WIDTH-1]}}, multiplicand};

	// digit selection, 0 / +-1 / +-2 times the multiplicand
	always_comb
	begin
		case (booth_code)
		3'b001, 3'b010: pp = mcand_ext;         // +1
		3'b011:         pp = mcand_ext <<< 1;   // +2
		3'b100:         pp = -(mcand_ext <<< 1); // -2
		3'b101, 3'b110: pp = -mcand_ext;        // -1
		default:        pp = '0;                // 000 and 111
		endcase
	end

	assign sum = acc_hi + pp; // 2 guard bits keep this from overflowing

	// arithmetic shift of {sum, acc_lo} by two
	assign new_acc_hi   = {{2{sum[OP_WIDTH+1]}}, sum[OP_WIDTH+1:2]};
	assign new_acc_lo   = {sum[1:0], acc_lo[OP_WIDTH-1:2]};
	assign new_prev_bit = acc_lo[1]; // top bit of the pair just consumed

endmodule

// ==== hw/booth_accumulator.sv ====
`timescale 1ns/100ps

module booth_accumulator
	import mul_pkg::*;
#(
	parameter int OP_WIDTH = MUL_OP_WIDTH_DEF
)
(
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         load_op,  // take new multiplier
	input  logic                         step_op,  // one booth iteration
	input  logic                         clear_op, // zero, wins over load/step
	input  logic signed [OP_WIDTH-1:0]   reg_multiplier,
	input  logic signed [OP_WIDTH-1:0]   reg_multiplicand,
	output logic signed [2*OP_WIDTH-1:0] result
);

	logic signed [OP_WIDTH+1:0] acc_hi;
	logic        [OP_WIDTH-1:0] acc_lo;   // shifts product bits in from the top
	logic                       prev_bit;
	logic signed [OP_WIDTH+1:0] step_hi;
	logic        [OP_WIDTH-1:0] step_lo;
	logic                       step_prev;

	booth_radix4_step #(
		.OP_WIDTH (OP_WIDTH)
	) u_step (
		.acc_hi       (acc_hi),
		.acc_lo       (acc_lo),
		.prev_bit     (prev_bit),
		.multiplicand (reg_multiplicand),
		.new_acc_hi   (step_hi),
		.new_acc_lo   (step_lo),
		.new_prev_bit (step_prev)
	);

	always_ff @(posedge clk)
	begin
		if (!reset_n || clear_op)
		begin
			acc_hi   <= '0;
			acc_lo   <= '0;
			prev_bit <= 1'b0;
		end
		else if (load_op)
		begin
			acc_hi   <= '0;             // nothing accumulated yet
			acc_lo   <= reg_multiplier; // recoded two bits per step
			prev_bit <= 1'b0;           // implicit zero below bit 0
		end
		else if (step_op)
		begin
			acc_hi   <= step_hi;
			acc_lo   <= step_lo;
			prev_bit <= step_prev;
		end
	end

	// low 2W bits of {hi, lo}, guard bits are only sign copies by now
	assign result = {acc_hi[OP_WIDTH-1:0], acc_lo};

	a_no_load_step: assert property (@(posedge clk) disable iff (!reset_n)
		!(load_op && step_op))
		else $error("load and step strobes overlap");

endmodule

// ==== hw/multiplier_top.sv ====
`timescale 1ns/100ps

module multiplier_top
	import mul_pkg::*;
#(
	parameter int OP_WIDTH = MUL_OP_WIDTH_DEF // even operand width
)
(
	input  logic                         clk,
	input  logic                         reset_n,
	input  logic                         op_start,
	input  logic                         op_clear,
	input  logic signed [OP_WIDTH-1:0]   multiplier,
	input  logic signed [OP_WIDTH-1:0]   multiplicand,
	output logic signed [2*OP_WIDTH-1:0] result,
	output logic                         op_done,
	output logic                         busy
);

	mul_state_t                 state; // seen here only by the check below
	logic signed [OP_WIDTH-1:0] reg_multiplier;
	logic signed [OP_WIDTH-1:0] reg_multiplicand;
	logic                       load_op;
	logic                       step_op;
	logic                       clear_op;

	multiplier_ctrl #(
		.OP_WIDTH (OP_WIDTH)
	) u_ctrl (
		.clk              (clk),
		.reset_n          (reset_n),
		.op_start         (op_start),
		.op_clear         (op_clear),
		.multiplier       (multiplier),
		.multiplicand     (multiplicand),
		.state            (state),
		.reg_multiplier   (reg_multiplier),
		.reg_multiplicand (reg_multiplicand),
		.load_op          (load_op),
		.step_op          (step_op),
		.clear_op         (clear_op),
		.op_done          (op_done),
		.busy             (busy)
	);

	booth_accumulator #(
		.OP_WIDTH (OP_WIDTH)
	) u_acc (
		.clk              (clk),
		.reset_n          (reset_n),
		.load_op          (load_op),
		.step_op          (step_op),
		.clear_op         (clear_op),
		.reg_multiplier   (reg_multiplier),
		.reg_multiplicand (reg_multiplicand),
		.result           (result)
	);

	// last step lands before DONE, product then left alone into the op_done cycle
	a_result_final: assert property (@(posedge clk) disable iff (!reset_n)
		(state == DONE) |=> ($stable(result) || $past(clear_op)))
		else $error("result changed after the last Booth step");

endmodule

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8, // clock period
	parameter int RESET_CYCLES = 5  // rising edges with reset low
)
(
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk; // free running
	end

	initial
	begin
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset_n = 1'b1; // release just after an edge
	end

endmodule

// ==== dv/multiplier_tb.sv ====
`timescale 1ns/100ps

module multiplier_tb
	import mul_pkg::*;
;

	localparam int OP_WIDTH = MUL_OP_WIDTH_DEF;
	localparam int PROD_W   = 2 * OP_WIDTH;
	localparam int LATENCY  = OP_WIDTH / 2 + 2; // start edge to op_done edge
	localparam int RUN_CYCLES = LATENCY + 4;    // one run plus rearm and slack
	localparam int NUM_RUNS   = 8 + 40 + 6;     // directed, random, the rest
	localparam int EXTRA_CYCLES = 30 + 25 + 20; // guard hold, clear watch, reset
	localparam int TIMEOUT_CYCLES = 2 * (NUM_RUNS * RUN_CYCLES + EXTRA_CYCLES) + 500;
	localparam logic signed [OP_WIDTH-1:0] MAX_POS = {1'b0, {(OP_WIDTH-1){1'b1}}};
	localparam logic signed [OP_WIDTH-1:0] MIN_NEG = {1'b1, {(OP_WIDTH-1){1'b0}}};

	logic                       clk;
	logic                       gen_rst_n;
	logic                       rst_drive; // extra reset for the mid-run case
	logic                       reset_n;
	logic                       op_start;
	logic                       op_clear;
	logic signed [OP_WIDTH-1:0] multiplier;
	logic signed [OP_WIDTH-1:0] multiplicand;
	logic signed [PROD_W-1:0]   result;
	logic                       op_done;
	logic                       busy;
	logic [15:0]                lfsr_state = 16'd6075;
	int                         cycle_count = 0;
	int                         errors = 0;
	int                         checks = 0;
	int                         tests = 0;
	int                         test_start_errors = 0;

	assign reset_n = gen_rst_n & rst_drive;

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(5)) u_clk (.clk(clk), .reset_n(gen_rst_n));

	multiplier_top #(.OP_WIDTH(OP_WIDTH)) dut0 (
		.clk          (clk),
		.reset_n      (reset_n),
		.op_start     (op_start),
		.op_clear     (op_clear),
		.multiplier   (multiplier),
		.multiplicand (multiplicand),
		.result       (result),
		.op_done      (op_done),
		.busy         (busy)
	);

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run stopped: no end after %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// 16-bit fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rand_operand(output logic signed [OP_WIDTH-1:0] v);
		v = '0;
		for (int i = 0; i < OP_WIDTH; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state); // one step per bit
			v = {v[OP_WIDTH-2:0], lfsr_state[0]};
		end
	endtask

	function automatic logic signed [PROD_W-1:0] expected_product(
		input logic signed [OP_WIDTH-1:0] a, input logic signed [OP_WIDTH-1:0] b);
		longint x;
		longint y;
		x = longint'(a); // sign extended
		y = longint'(b);
		return x * y;
	endfunction

	task automatic check_result(input logic signed [PROD_W-1:0] got,
		input logic signed [PROD_W-1:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_state(input mul_state_t got, input mul_state_t exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s got %s expected %s", $time, what, got.name(), exp.name());
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_cycles(input int got, input int exp, input string what);
		checks++;
		if (got != exp)
		begin
			errors++;
			$display("[FAIL] %0d ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic tick();
		@(posedge clk);
		#1; // drive and sample off the edge
	endtask

	task automatic rearm();
		op_start = 1'b0; // low in IDLE rearms the guard
		tick();
		check_flag(op_done, 1'b0, "op_done past one cycle");
	endtask

	// start, optional pause of pause_len cycles after edge pause_at, then check
	task automatic run_op(input logic signed [OP_WIDTH-1:0] a,
		input logic signed [OP_WIDTH-1:0] b, input int pause_at, input int pause_len);
		int  n;
		int  exp_cycles;
		logic seen;
		n = 0;
		seen = 1'b0;
		exp_cycles = LATENCY + pause_len;
		multiplier = a;
		multiplicand = b;
		op_start = 1'b1; // next edge is the start edge
		tick(); // start edge, n counts the edges after it
		while (!seen && n < exp_cycles + 20)
		begin
			tick();
			n++;
			if (op_done)
				seen = 1'b1;
			else if (n < exp_cycles)
				check_flag(busy, 1'b1, "busy during run");
			if (pause_len > 0 && n == pause_at)
				op_start = 1'b0;
			if (pause_len > 0 && n == pause_at + pause_len)
				op_start = 1'b1;
		end
		if (!seen)
		begin
			errors++;
			$display("op_done never came for %0d * %0d within %0d cycles", a, b, n);
		end
		else
		begin
			check_cycles(n, exp_cycles, "cycles to op_done");
			check_result(result, expected_product(a, b), "product");
		end
	endtask

	task automatic begin_test();
		test_start_errors = errors;
		tests++;
	endtask

	task automatic end_test(input string name);
		$display("test %s errors %0d", name, errors - test_start_errors);
	endtask

	task automatic test_directed();
		begin_test();
		run_op(0, 123456, 0, 0);
		rearm();
		run_op(1, -1, 0, 0);
		rearm();
		run_op(-1, -1, 0, 0);
		rearm();
		run_op(MAX_POS, MAX_POS, 0, 0);
		rearm();
		run_op(MIN_NEG, MIN_NEG, 0, 0); // most negative squared
		rearm();
		run_op(MAX_POS, MIN_NEG, 0, 0);
		rearm();
		run_op(-7, 9, 0, 0);
		rearm();
		run_op(12345, -678, 0, 0);
		rearm();
		end_test("directed");
	endtask

	task automatic test_random();
		logic signed [OP_WIDTH-1:0] a;
		logic signed [OP_WIDTH-1:0] b;
		begin_test();
		repeat (40)
		begin
			rand_operand(a);
			rand_operand(b);
			run_op(a, b, 0, 0);
			rearm();
		end
		end_test("random");
	endtask

	task automatic test_pause();
		begin_test();
		run_op(-31415, 27182, 6, 3); // early in the run
		rearm();
		run_op(MIN_NEG, 3, 16, 2); // right before the last step
		rearm();
		end_test("pause");
	endtask

	task automatic test_clear();
		begin_test();
		multiplier = 32'sd99991;
		multiplicand = -32'sd4242;
		op_start = 1'b1;
		repeat (8)
		begin
			tick();
			check_flag(op_done, 1'b0, "op_done before clear");
		end
		op_clear = 1'b1; // mid exec
		op_start = 1'b0;
		tick();
		op_clear = 1'b0;
		check_result(result, '0, "result after clear");
		check_state(dut0.u_ctrl.state, IDLE, "state after clear");
		repeat (25)
		begin
			tick();
			check_flag(op_done, 1'b0, "op_done after clear");
		end
		run_op(-77, -88, 0, 0); // normal start afterwards
		rearm();
		end_test("clear");
	endtask

	task automatic test_guard();
		begin_test();
		run_op(1001, -2002, 0, 0);
		repeat (30) // start held, same pair
		begin
			tick();
			check_flag(busy, 1'b0, "busy with guard disarmed");
		end
		check_state(dut0.u_ctrl.state, IDLE, "state with guard disarmed");
		run_op(1001, -2003, 0, 0); // new operand starts at once
		rearm();
		end_test("guard");
	endtask

	task automatic test_reset();
		begin_test();
		multiplier = -32'sd123;
		multiplicand = 32'sd456789;
		op_start = 1'b1;
		repeat (7) tick();
		rst_drive = 1'b0;
		op_start = 1'b0;
		tick();
		check_result(result, '0, "result in reset");
		check_flag(op_done, 1'b0, "op_done in reset");
		check_flag(busy, 1'b0, "busy in reset");
		check_state(dut0.u_ctrl.state, IDLE, "state in reset");
		rst_drive = 1'b1;
		tick();
		run_op(-123, 456789, 0, 0);
		rearm();
		end_test("reset");
	endtask

	initial
	begin
		rst_drive = 1'b1;
		op_start = 1'b0;
		op_clear = 1'b0;
		multiplier = '0;
		multiplicand = '0;
		wait (gen_rst_n === 1'b1);
		tick();
		test_directed();
		test_random();
		test_pause();
		test_clear();
		test_guard();
		test_reset();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== sources.f ====
hw/mul_pkg.sv
hw/multiplier_ns.sv
hw/multiplier_ctrl.sv
hw/booth_radix4_step.sv
hw/booth_accumulator.sv
hw/multiplier_top.sv
dv/tb_clock_gen.sv
dv/multiplier_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := multiplier_tb
FILELIST := sources.f
OUTDIR   := obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OUTDIR)
	out="$$(./$(OUTDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(OUTDIR)
